/* rv32i_core.f */
+incdir+source
source/rv32i_types_pkg.sv
source/pipe_types_pkg.sv
source/cpu_control.sv
source/regfile.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv32i_core.sv
sim/tb_rv32i_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_rv32i_core -f rv32i_core.f

./obj_dir/Vtb_rv32i_core | tee sim.log

if grep -q "^Everything OK$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi

/* sim/tb_rv32i_core.sv */
module tb_rv32i_core;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_INSTR = 300;
	localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 100;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0] rd;
		logic we;
		logic [31:0] data;
		logic branch;
		logic taken;
		logic [31:0] target;
	} retire_item_t;

	logic clk, rst;
	logic instr_valid, instr_ready;
	logic [31:0] instr, instr_pc;
	logic retire_valid, retire_ready, retire_we, retire_branch_taken;
	logic [31:0] retire_pc, retire_data, retire_branch_target;
	logic [4:0] retire_rd;

	logic [31:0] xreg [32]; // Reference register file
	logic [31:0] dmem [64]; // Reference data memory
	bit written [64];
	bit any_written;
	retire_item_t exp_q [$];
	retire_item_t exp_head;
	logic exp_valid, in_fire, out_fire, ret_xfer;
	int sent, retired;
	int cycle_count = 0;

	rv32i_core u_dut (
		.clk(clk), .rst(rst),
		.instr_valid(instr_valid), .instr_ready(instr_ready),
		.instr(instr), .instr_pc(instr_pc),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_pc(retire_pc), .retire_rd(retire_rd), .retire_we(retire_we),
		.retire_data(retire_data), .retire_branch_taken(retire_branch_taken),
		.retire_branch_target(retire_branch_target)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "Run stopped");
	endtask

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic is_reg, input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return (is_reg && alt) ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Random instruction from the supported classes, registers limited to x0..x7
	task automatic gen_instr(output logic [31:0] ins);
		logic [31:0] r, u;
		logic [4:0] rd, r1, r2;
		logic [2:0] f3;
		logic [5:0] word;
		logic [11:0] off;
		logic [3:0] kind;
		logic alt;
		r = $urandom;
		u = $urandom;
		rd = {2'b00, r[2:0]};
		r1 = {2'b00, r[5:3]};
		r2 = {2'b00, r[8:6]};
		f3 = r[11:9];
		alt = r[12];
		word = r[18:13];
		kind = 4'($urandom % 9);
		if (kind == 4'd6 && !any_written)
			kind = 4'd7; // Nothing stored yet, so no load
		case (kind)
			4'd0: ins = {u[31:12], rd, 7'b0110111};
			4'd1: ins = {u[31:12], rd, 7'b0010111};
			4'd2, 4'd3: begin
				if (f3 == 3'b001 || f3 == 3'b101)
					ins = {1'b0, alt && f3 == 3'b101, 5'b0, u[4:0], r1, f3, rd, 7'b0010011};
				else
					ins = {u[11:0], r1, f3, rd, 7'b0010011};
			end
			4'd4, 4'd5: ins = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
				r2, r1, f3, rd, 7'b0110011};
			4'd6: begin
				while (!written[word])
					word = word + 6'd1;
				ins = {4'b0, word, 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
			end
			4'd7: begin
				off = {4'b0, word, 2'b00};
				written[word] = 1'b1;
				any_written = 1'b1;
				ins = {off[11:5], r2, 5'd0, 3'b010, off[4:0], 7'b0100011};
			end
			default: begin
				if (f3[2:1] == 2'b01)
					f3 = f3 ^ 3'b110; // 2 and 3 are not branches
				ins = {u[12], u[10:5], r2, r1, f3, u[4:1], u[11], 7'b1100011};
			end
		endcase
	endtask

	// Executes one accepted instruction and queues what must retire
	task automatic model_exec(input logic [31:0] ins, input logic [31:0] pc);
		retire_item_t item;
		logic [31:0] a, b, ii, si, ui, res, addr;
		logic [4:0] rd;
		a = xreg[ins[19:15]];
		b = xreg[ins[24:20]];
		rd = ins[11:7];
		ii = {{20{ins[31]}}, ins[31:20]};
		si = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		ui = {ins[31:12], 12'h000};
		res = 32'h0;
		item = '0;
		item.pc = pc;
		item.rd = rd;
		case (ins[6:0])
			7'b0110111: res = ui;
			7'b0010111: res = pc + ui;
			7'b0010011: res = alu_ref(ins[14:12], ins[30], 1'b0, a, ii);
			7'b0110011: res = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
			7'b0000011: begin
				addr = a + ii;
				res = dmem[addr[7:2]];
			end
			7'b0100011: begin
				addr = a + si;
				dmem[addr[7:2]] = b;
			end
			default: begin
				item.branch = 1'b1;
				item.taken = branch_ref(ins[14:12], a, b);
				item.target = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			end
		endcase
		item.we = ins[6:0] inside {7'b0110111, 7'b0010111, 7'b0010011, 7'b0110011, 7'b0000011};
		item.data = res;
		if (item.we && rd != 5'd0)
			xreg[rd] = res;
		exp_q.push_back(item);
	endtask

	assign ret_xfer = retire_valid && retire_ready;

	// Handshakes as seen just before the rising edge
	always @(posedge clk) begin
		in_fire <= instr_valid && instr_ready;
		out_fire <= ret_xfer;
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES)
			report_fail($sformatf("Timeout: %0d of %0d retired", retired, NUM_INSTR));
	end

	a_retire_expected: assert property (@(posedge clk) disable iff (rst) ret_xfer |-> exp_valid)
		else report_fail($sformatf("Retire at %0t with no instruction outstanding", $time));
	a_retire_pc: assert property (@(posedge clk) disable iff (rst)
		ret_xfer && exp_valid |-> retire_pc == exp_head.pc)
		else report_fail($sformatf("error %0t: retire_pc %h, expected %h",
			$time, $sampled(retire_pc), exp_head.pc));
	a_retire_rd: assert property (@(posedge clk) disable iff (rst)
		ret_xfer && exp_valid |-> retire_rd == exp_head.rd && retire_we == exp_head.we)
		else report_fail($sformatf("error %0t: pc %h rd %0d we %b, expected rd %0d we %b",
			$time, exp_head.pc, $sampled(retire_rd), $sampled(retire_we),
			exp_head.rd, exp_head.we));
	a_retire_data: assert property (@(posedge clk) disable iff (rst)
		ret_xfer && exp_valid && exp_head.we |-> retire_data == exp_head.data)
		else report_fail($sformatf("error %0t: pc %h data %h, expected %h",
			$time, exp_head.pc, $sampled(retire_data), exp_head.data));
	a_retire_branch: assert property (@(posedge clk) disable iff (rst)
		ret_xfer && exp_valid |-> retire_branch_taken == exp_head.taken &&
		(!exp_head.branch || retire_branch_target == exp_head.target))
		else report_fail($sformatf("error %0t: pc %h taken %b target %h, expected %b %h",
			$time, exp_head.pc, $sampled(retire_branch_taken),
			$sampled(retire_branch_target), exp_head.taken, exp_head.target));
	a_retire_hold: assert property (@(posedge clk) disable iff (rst)
		retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc) &&
		$stable(retire_rd) && $stable(retire_we) && $stable(retire_data) &&
		$stable(retire_branch_taken) && $stable(retire_branch_target))
		else report_fail($sformatf("Retire item changed at %0t while retire_ready was low", $time));

	initial begin
		logic [31:0] next_instr;
		void'($urandom(32'he1b8_0df6));
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = 32'h0;
		instr_pc = 32'h0;
		retire_ready = 1'b0;
		in_fire = 1'b0;
		out_fire = 1'b0;
		exp_valid = 1'b0;
		exp_head = '0;
		foreach (xreg[i])
			xreg[i] = 32'h0;
		foreach (written[i])
			written[i] = 1'b0;
		any_written = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		a_reset_state: assert (!retire_valid && instr_ready)
			else report_fail("After reset retire_valid is not low or instr_ready is not high");
		while (retired < NUM_INSTR) begin
			@(negedge clk);
			if (out_fire) begin
				void'(exp_q.pop_front());
				retired++;
			end
			if (in_fire) begin
				model_exec(instr, instr_pc);
				sent++;
				instr_valid = 1'b0;
			end
			exp_valid = exp_q.size() != 0;
			if (exp_valid)
				exp_head = exp_q[0];
			if (!instr_valid && sent < NUM_INSTR && $urandom % 4 != 0) begin
				gen_instr(next_instr);
				instr = next_instr;
				instr_pc = 32'h0000_1000 + 32'(sent) * 4;
				instr_valid = 1'b1;
			end
			retire_ready = $urandom % 4 != 0; // Random back-pressure
		end
		repeat (4) @(negedge clk);
		if (!retire_valid) begin
			$display("Everything OK");
			$finish;
		end else begin
			report_fail("Retire stream produced more items than instructions sent");
		end
	end

endmodule : tb_rv32i_core

/* source/rv32i_core.sv */
module rv32i_core import rv32i_types::*, pipe_types::*; (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	output logic instr_ready,
	input rv32i_word instr,
	input rv32i_word instr_pc,
	output logic retire_valid,
	input logic retire_ready,
	output rv32i_word retire_pc,
	output rv32i_reg retire_rd,
	output logic retire_we,
	output rv32i_word retire_data,
	output logic retire_branch_taken,
	output rv32i_word retire_branch_target
);

	rv32i_reg rs1, rs2;
	rv32i_word rs1_data, rs2_data;

	logic de_valid, de_ready;
	rv32i_word de_pc, de_rs1_data, de_rs2_data, de_imm;
	rv32i_reg de_rd;
	alu_ops de_aluop;
	branch_funct3_t de_cmpop;
	alumux1_sel_t de_alumux1_sel;
	alumux2_sel_t de_alumux2_sel;
	cmpmux_sel_t de_cmpmux_sel;
	wbmux_sel_t de_wbmux_sel;
	logic de_load_regfile, de_mem_read, de_mem_write, de_is_branch;

	logic ex_valid, ex_ready, ex_we, ex_cmp, ex_mem_read, ex_mem_write, ex_branch_taken;
	rv32i_word ex_pc, ex_alu, ex_store_data, ex_imm, ex_branch_target;
	rv32i_reg ex_rd;
	wbmux_sel_t ex_wbmux_sel;

	regfile u_regfile (
		.clk(clk), .rst(rst),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.we(retire_valid && retire_ready && retire_we), // Write on retire transfer
		.rd(retire_rd), .wdata(retire_data)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst),
		.instr_valid(instr_valid), .instr_ready(instr_ready),
		.instr(instr), .instr_pc(instr_pc),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.ex_rd(ex_rd), .ex_we_pending(ex_valid && ex_we),
		.mem_rd(retire_rd), .mem_we_pending(retire_valid && retire_we),
		.out_valid(de_valid), .out_ready(de_ready), .out_pc(de_pc),
		.out_rs1_data(de_rs1_data), .out_rs2_data(de_rs2_data), .out_imm(de_imm),
		.out_rd(de_rd), .out_aluop(de_aluop), .out_cmpop(de_cmpop),
		.out_alumux1_sel(de_alumux1_sel), .out_alumux2_sel(de_alumux2_sel),
		.out_cmpmux_sel(de_cmpmux_sel), .out_wbmux_sel(de_wbmux_sel),
		.out_load_regfile(de_load_regfile), .out_mem_read(de_mem_read),
		.out_mem_write(de_mem_write), .out_is_branch(de_is_branch)
	);

	execute_stage u_execute (
		.clk(clk), .rst(rst),
		.in_valid(de_valid), .in_ready(de_ready), .in_pc(de_pc),
		.in_rs1_data(de_rs1_data), .in_rs2_data(de_rs2_data), .in_imm(de_imm),
		.in_rd(de_rd), .in_aluop(de_aluop), .in_cmpop(de_cmpop),
		.in_alumux1_sel(de_alumux1_sel), .in_alumux2_sel(de_alumux2_sel),
		.in_cmpmux_sel(de_cmpmux_sel), .in_wbmux_sel(de_wbmux_sel),
		.in_load_regfile(de_load_regfile), .in_mem_read(de_mem_read),
		.in_mem_write(de_mem_write), .in_is_branch(de_is_branch),
		.out_valid(ex_valid), .out_ready(ex_ready), .out_pc(ex_pc), .out_rd(ex_rd),
		.out_we(ex_we), .out_alu(ex_alu), .out_cmp(ex_cmp),
		.out_store_data(ex_store_data), .out_imm(ex_imm),
		.out_mem_read(ex_mem_read), .out_mem_write(ex_mem_write),
		.out_wbmux_sel(ex_wbmux_sel), .out_branch_taken(ex_branch_taken),
		.out_branch_target(ex_branch_target)
	);

	memory_stage u_memory (
		.clk(clk), .rst(rst),
		.in_valid(ex_valid), .in_ready(ex_ready), .in_pc(ex_pc), .in_rd(ex_rd),
		.in_we(ex_we), .in_alu(ex_alu), .in_cmp(ex_cmp),
		.in_store_data(ex_store_data), .in_imm(ex_imm),
		.in_mem_read(ex_mem_read), .in_mem_write(ex_mem_write),
		.in_wbmux_sel(ex_wbmux_sel), .in_branch_taken(ex_branch_taken),
		.in_branch_target(ex_branch_target),
		.retire_valid(retire_valid), .retire_ready(retire_ready),
		.retire_pc(retire_pc), .retire_rd(retire_rd), .retire_we(retire_we),
		.retire_data(retire_data), .retire_branch_taken(retire_branch_taken),
		.retire_branch_target(retire_branch_target)
	);

endmodule : rv32i_core

/* source/memory_stage.sv */
`include "cpu_macros.svh"

module memory_stage import pipe_types::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input rv32i_word in_pc,
	input rv32i_reg in_rd,
	input logic in_we,
	input rv32i_word in_alu,
	input logic in_cmp,
	input rv32i_word in_store_data,
	input rv32i_word in_imm,
	input logic in_mem_read,
	input logic in_mem_write,
	input wbmux_sel_t in_wbmux_sel,
	input logic in_branch_taken,
	input rv32i_word in_branch_target,
	output logic retire_valid,
	input logic retire_ready,
	output rv32i_word retire_pc,
	output rv32i_reg retire_rd,
	output logic retire_we,
	output rv32i_word retire_data,
	output logic retire_branch_taken,
	output rv32i_word retire_branch_target
);

	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	rv32i_word dmem [`DMEM_WORDS];
	logic [DMEM_AW-1:0] word_addr;
	rv32i_word load_data, wb_data;
	logic take;

	assign word_addr = in_alu[DMEM_AW+1:2];
	assign load_data = in_mem_read ? dmem[word_addr] : '0;
	assign in_ready = !retire_valid || retire_ready;
	assign take = in_valid && in_ready;

	always_comb begin
		case (in_wbmux_sel)
			wb_cmp: wb_data = {{(`XLEN-1){1'b0}}, in_cmp};
			wb_u_imm: wb_data = in_imm;
			wb_load: wb_data = load_data;
			default: wb_data = in_alu;
		endcase
	end

	always_ff @(posedge clk) begin
		if (take && in_mem_write)
			dmem[word_addr] <= in_store_data; // Store lands as it enters
	end

	always_ff @(posedge clk) begin
		if (rst)
			retire_valid <= 1'b0;
		else if (in_ready)
			retire_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			retire_pc <= in_pc;
			retire_rd <= in_rd;
			retire_we <= in_we;
			retire_data <= wb_data;
			retire_branch_taken <= in_branch_taken;
			retire_branch_target <= in_branch_target;
		end
	end

	a_word_aligned: assert property (@(posedge clk) disable iff (rst)
		in_valid && (in_mem_read || in_mem_write) |-> in_alu[1:0] == 2'b00);

endmodule : memory_stage

/* source/execute_stage.sv */
module execute_stage import rv32i_types::*, pipe_types::*; (
	input logic clk,
	input logic rst,
	input logic in_valid,
	output logic in_ready,
	input rv32i_word in_pc,
	input rv32i_word in_rs1_data,
	input rv32i_word in_rs2_data,
	input rv32i_word in_imm,
	input rv32i_reg in_rd,
	input alu_ops in_aluop,
	input branch_funct3_t in_cmpop,
	input alumux1_sel_t in_alumux1_sel,
	input alumux2_sel_t in_alumux2_sel,
	input cmpmux_sel_t in_cmpmux_sel,
	input wbmux_sel_t in_wbmux_sel,
	input logic in_load_regfile,
	input logic in_mem_read,
	input logic in_mem_write,
	input logic in_is_branch,
	output logic out_valid,
	input logic out_ready,
	output rv32i_word out_pc,
	output rv32i_reg out_rd,
	output logic out_we,
	output rv32i_word out_alu,
	output logic out_cmp,
	output rv32i_word out_store_data,
	output rv32i_word out_imm,
	output logic out_mem_read,
	output logic out_mem_write,
	output wbmux_sel_t out_wbmux_sel,
	output logic out_branch_taken,
	output rv32i_word out_branch_target
);

	rv32i_word alu_a, alu_b, cmp_b, alu_out;
	logic cmp_out;

	assign alu_a = (in_alumux1_sel == alumux1_pc) ? in_pc : in_rs1_data;
	assign alu_b = (in_alumux2_sel == alumux2_rs2) ? in_rs2_data : in_imm;
	assign cmp_b = (in_cmpmux_sel == cmpmux_i_imm) ? in_imm : in_rs2_data;

	always_comb begin
		case (in_aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_sll: alu_out = alu_a << alu_b[4:0];
			alu_sra: alu_out = rv32i_word'($signed(alu_a) >>> alu_b[4:0]);
			alu_sub: alu_out = alu_a - alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_srl: alu_out = alu_a >> alu_b[4:0];
			alu_or: alu_out = alu_a | alu_b;
			default: alu_out = alu_a & alu_b;
		endcase
	end

	always_comb begin
		case (in_cmpop)
			beq: cmp_out = in_rs1_data == cmp_b;
			bne: cmp_out = in_rs1_data != cmp_b;
			blt: cmp_out = $signed(in_rs1_data) < $signed(cmp_b);
			bge: cmp_out = $signed(in_rs1_data) >= $signed(cmp_b);
			bltu: cmp_out = in_rs1_data < cmp_b;
			bgeu: cmp_out = in_rs1_data >= cmp_b;
			default: cmp_out = 1'b0;
		endcase
	end

	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_pc <= in_pc;
			out_rd <= in_rd;
			out_we <= in_load_regfile;
			out_alu <= alu_out;
			out_cmp <= cmp_out;
			out_store_data <= in_rs2_data;
			out_imm <= in_imm;
			out_mem_read <= in_mem_read;
			out_mem_write <= in_mem_write;
			out_wbmux_sel <= in_wbmux_sel;
			out_branch_taken <= in_is_branch && cmp_out;
			out_branch_target <= alu_out; // pc + b immediate for branches
		end
	end

	a_branch_no_write: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready && in_is_branch |=> !out_we);

endmodule : execute_stage

/* source/decode_stage.sv */
module decode_stage import rv32i_types::*, pipe_types::*; (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	output logic instr_ready,
	input rv32i_word instr,
	input rv32i_word instr_pc,
	output rv32i_reg rs1,
	output rv32i_reg rs2,
	input rv32i_word rs1_data,
	input rv32i_word rs2_data,
	input rv32i_reg ex_rd,
	input logic ex_we_pending,
	input rv32i_reg mem_rd,
	input logic mem_we_pending,
	output logic out_valid,
	input logic out_ready,
	output rv32i_word out_pc,
	output rv32i_word out_rs1_data,
	output rv32i_word out_rs2_data,
	output rv32i_word out_imm,
	output rv32i_reg out_rd,
	output alu_ops out_aluop,
	output branch_funct3_t out_cmpop,
	output alumux1_sel_t out_alumux1_sel,
	output alumux2_sel_t out_alumux2_sel,
	output cmpmux_sel_t out_cmpmux_sel,
	output wbmux_sel_t out_wbmux_sel,
	output logic out_load_regfile,
	output logic out_mem_read,
	output logic out_mem_write,
	output logic out_is_branch
);

	rv32i_reg rd;
	rv32i_word imm;
	alu_ops aluop;
	branch_funct3_t cmpop;
	alumux1_sel_t alumux1_sel;
	alumux2_sel_t alumux2_sel;
	cmpmux_sel_t cmpmux_sel;
	wbmux_sel_t wbmux_sel;
	logic load_regfile, mem_read, mem_write, is_branch;
	logic rs1_hit, rs2_hit, ld_en;

	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	cpu_control u_control (
		.opcode(rv32i_opcode'(instr[6:0])),
		.funct3(instr[14:12]),
		.funct7(instr[31:25]),
		.aluop(aluop),
		.cmpop(cmpop),
		.alumux1_sel(alumux1_sel),
		.alumux2_sel(alumux2_sel),
		.cmpmux_sel(cmpmux_sel),
		.wbmux_sel(wbmux_sel),
		.load_regfile(load_regfile),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.is_branch(is_branch)
	);

	always_comb begin
		case (alumux2_sel)
			alumux2_u_imm: imm = {instr[31:12], 12'h000};
			alumux2_b_imm: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			alumux2_s_imm: imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			default: imm = {{21{instr[31]}}, instr[30:20]}; // I-type, also slti compare
		endcase
		if (wbmux_sel == wb_u_imm)
			imm = {instr[31:12], 12'h000}; // lui
	end

	// Any pending writer in decode, execute or retire blocks the read
	assign rs1_hit = rs1 != '0 && ((out_valid && out_load_regfile && rs1 == out_rd) ||
		(ex_we_pending && rs1 == ex_rd) || (mem_we_pending && rs1 == mem_rd));
	assign rs2_hit = rs2 != '0 && ((out_valid && out_load_regfile && rs2 == out_rd) ||
		(ex_we_pending && rs2 == ex_rd) || (mem_we_pending && rs2 == mem_rd));

	assign ld_en = !out_valid || out_ready;
	assign instr_ready = ld_en && !rs1_hit && !rs2_hit;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (ld_en)
			out_valid <= instr_valid && instr_ready;
	end

	always_ff @(posedge clk) begin
		if (instr_valid && instr_ready) begin
			out_pc <= instr_pc;
			out_rs1_data <= rs1_data;
			out_rs2_data <= rs2_data;
			out_imm <= imm;
			out_rd <= rd;
			out_aluop <= aluop;
			out_cmpop <= cmpop;
			out_alumux1_sel <= alumux1_sel;
			out_alumux2_sel <= alumux2_sel;
			out_cmpmux_sel <= cmpmux_sel;
			out_wbmux_sel <= wbmux_sel;
			out_load_regfile <= load_regfile;
			out_mem_read <= mem_read;
			out_mem_write <= mem_write;
			out_is_branch <= is_branch;
		end
	end

	a_hold_until_taken: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_rd));

endmodule : decode_stage

/* source/regfile.sv */
`include "cpu_macros.svh"

module regfile import pipe_types::*; (
	input logic clk,
	input logic rst,
	input rv32i_reg rs1,
	input rv32i_reg rs2,
	output rv32i_word rs1_data,
	output rv32i_word rs2_data,
	input logic we,
	input rv32i_reg rd,
	input rv32i_word wdata
);

	rv32i_word regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	// Same-cycle write is visible on the read ports
	assign rs1_data = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule : regfile

/* source/cpu_control.sv */
module cpu_control import rv32i_types::*, pipe_types::*; (
	input rv32i_opcode opcode,
	input logic [2:0] funct3,
	input logic [6:0] funct7,
	output alu_ops aluop,
	output branch_funct3_t cmpop,
	output alumux1_sel_t alumux1_sel,
	output alumux2_sel_t alumux2_sel,
	output cmpmux_sel_t cmpmux_sel,
	output wbmux_sel_t wbmux_sel,
	output logic load_regfile,
	output logic mem_read,
	output logic mem_write,
	output logic is_branch
);

	arith_funct3_t arith_funct3;

	assign arith_funct3 = arith_funct3_t'(funct3);

	always_comb begin
		aluop = alu_add;
		cmpop = branch_funct3_t'(funct3); // Branches compare by their own funct3
		alumux1_sel = alumux1_rs1;
		alumux2_sel = alumux2_i_imm;
		cmpmux_sel = cmpmux_rs2;
		wbmux_sel = wb_alu;
		load_regfile = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;

		case (opcode)
			op_lui: begin
				load_regfile = 1'b1;
				wbmux_sel = wb_u_imm;
			end
			op_auipc: begin
				load_regfile = 1'b1;
				alumux1_sel = alumux1_pc;
				alumux2_sel = alumux2_u_imm;
			end
			op_br: begin
				is_branch = 1'b1;
				alumux1_sel = alumux1_pc; // ALU forms the target
				alumux2_sel = alumux2_b_imm;
			end
			op_load: begin
				load_regfile = 1'b1;
				mem_read = 1'b1;
				wbmux_sel = wb_load;
			end
			op_store: begin
				mem_write = 1'b1;
				alumux2_sel = alumux2_s_imm;
			end
			op_imm: begin
				load_regfile = 1'b1;
				aluop = alu_ops'(funct3);
				case (arith_funct3)
					slt: begin
						cmpop = blt;
						cmpmux_sel = cmpmux_i_imm;
						wbmux_sel = wb_cmp;
					end
					sltu: begin
						cmpop = bltu;
						cmpmux_sel = cmpmux_i_imm;
						wbmux_sel = wb_cmp;
					end
					sr: aluop = funct7[5] ? alu_sra : alu_srl;
					default: ;
				endcase
			end
			op_reg: begin
				load_regfile = 1'b1;
				alumux2_sel = alumux2_rs2;
				aluop = alu_ops'(funct3);
				case (arith_funct3)
					add: aluop = funct7[5] ? alu_sub : alu_add;
					slt: begin
						cmpop = blt;
						wbmux_sel = wb_cmp;
					end
					sltu: begin
						cmpop = bltu;
						wbmux_sel = wb_cmp;
					end
					sr: aluop = funct7[5] ? alu_sra : alu_srl;
					default: ;
				endcase
			end
			default: ; // jal, jalr and csr are not supported
		endcase
	end

endmodule : cpu_control

/* source/pipe_types_pkg.sv */
`include "cpu_macros.svh"

package pipe_types;

	typedef logic [`XLEN-1:0] rv32i_word;
	typedef logic [$clog2(`REG_COUNT)-1:0] rv32i_reg;

	typedef enum logic {
		alumux1_rs1 = 1'b0,
		alumux1_pc  = 1'b1
	} alumux1_sel_t;

	typedef enum logic [2:0] {
		alumux2_i_imm = 3'd0,
		alumux2_u_imm = 3'd1,
		alumux2_b_imm = 3'd2,
		alumux2_s_imm = 3'd3,
		alumux2_rs2   = 3'd4
	} alumux2_sel_t;

	typedef enum logic {
		cmpmux_rs2   = 1'b0,
		cmpmux_i_imm = 1'b1
	} cmpmux_sel_t;

	typedef enum logic [1:0] {
		wb_alu   = 2'd0,
		wb_cmp   = 2'd1,
		wb_u_imm = 2'd2,
		wb_load  = 2'd3
	} wbmux_sel_t;

endpackage : pipe_types

/* source/rv32i_types_pkg.sv */
package rv32i_types;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011,
		op_csr   = 7'b1110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101, // srl or sra by funct7
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	// Lines up with funct3 so a cast gives the op
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

endpackage : rv32i_types

/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath width in bits
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// Data memory depth, 32-bit words
`define DMEM_WORDS 64

`endif
